// ==== adc_uart_pkg.sv ====
// ADC to UART shared definitions
`default_nettype none

package adc_uart_pkg;

	// host write bus fields.
	typedef logic [7:0]  addr_t;
	typedef logic [15:0] wrdata_t;

	// one parallel ADC result.
	typedef logic [7:0] adc_data_t;

	// baud code from 9600 up to 115200.
	typedef logic [2:0] baud_sel_t;

	// sampler registers.
	localparam addr_t ADDR_SMP_PERIOD = 8'd0;
	localparam addr_t ADDR_SMP_EN     = 8'd1;

	// transmit controller registers.
	localparam addr_t ADDR_TX_EN = 8'd4;
	localparam addr_t ADDR_BAUD  = 8'd5;

	// clock cycles per bit for a baud code, rounded down.
	function automatic logic [15:0] baud_divisor(input int unsigned clk_freq_hz,
		input baud_sel_t sel);
		int unsigned rate;
		case (sel)
			3'd1:    rate = 19200;
			3'd2:    rate = 38400;
			3'd3:    rate = 57600;
			3'd4:    rate = 115200;
			// codes 0 and 5 to 7 run at 9600.
			default: rate = 9600;
		endcase
		return 16'(clk_freq_hz / rate);
	endfunction

endpackage

`default_nettype wire

// ==== uart_tx_if.sv ====
// UART transmit link
`timescale 1ns/1ps
`default_nettype none

interface uart_tx_if;
	import adc_uart_pkg::*;

	// one-cycle send request.
	logic      byte_en;
	// byte and baud code, valid with byte_en.
	adc_data_t data_byte;
	baud_sel_t baud_set;
	// one-cycle pulse in the last stop bit cycle.
	logic      tx_done;

	// controller side.
	modport ctrl (output byte_en, output data_byte, output baud_set, input tx_done);

	// serial transmitter side.
	modport phy (input byte_en, input data_byte, input baud_set, output tx_done);

endinterface

`default_nettype wire

// ==== adc_sampler.sv ====
// Periodic ADC sampler
`timescale 1ns/1ps
`default_nettype none

module adc_sampler (
	input  logic                    Clk,
	input  logic                    Rst_n,
	input  logic                    wr,
	input  adc_uart_pkg::addr_t     addr,
	input  adc_uart_pkg::wrdata_t   wrdata,
	output logic                    adc_conv,
	input  logic                    adc_busy,
	input  adc_uart_pkg::adc_data_t adc_data,
	output logic                    adc_flag,
	output adc_uart_pkg::adc_data_t adc_result
);
	import adc_uart_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_CONV, ST_CAPT} state_t;

	// host registers.
	logic [15:0] smp_period;
	logic        smp_en;
	// period counter and conversion sequencing.
	logic [15:0] cnt;
	logic        due;
	state_t      state;
	logic [1:0]  hold;

	// a sample is due on the last cycle of the period.
	assign due = smp_en && (cnt == smp_period - 16'd1);

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			smp_period <= 16'd0;
			smp_en     <= 1'b0;
		end else if (wr && (addr == ADDR_SMP_PERIOD)) begin
			smp_period <= wrdata;
		end else if (wr && (addr == ADDR_SMP_EN)) begin
			smp_en <= wrdata[0];
		end
	end

	// restarts on an enable write and after each due cycle.
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n)
			cnt <= 16'd0;
		else if ((wr && (addr == ADDR_SMP_EN)) || !smp_en || due)
			cnt <= 16'd0;
		else
			cnt <= cnt + 16'd1;
	end

	// due cycles outside idle are skipped.
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state    <= ST_IDLE;
			hold     <= 2'd0;
			adc_conv <= 1'b0;
			adc_flag <= 1'b0;
		end else begin
			adc_conv <= 1'b0;
			adc_flag <= 1'b0;
			case (state)
				ST_IDLE: if (due) begin
					adc_conv <= 1'b1;
					hold     <= 2'd2;
					state    <= ST_CONV;
				end
				// busy is ignored for two cycles after the start pulse.
				ST_CONV: if (hold != 2'd0)
					hold <= hold - 2'd1;
				else if (!adc_busy)
					state <= ST_CAPT;
				ST_CAPT: begin
					adc_flag <= 1'b1;
					state    <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// result register.
	always_ff @(posedge Clk) begin
		if (state == ST_CAPT)
			adc_result <= adc_data;
	end

	// no second start pulse before the previous result is flagged.
	a_no_conv_overlap: assert property (@(posedge Clk) disable iff (!Rst_n)
		adc_conv |=> !adc_conv throughout adc_flag[->1]);

endmodule

`default_nettype wire

// ==== uart_tx_ctrl.sv ====
// UART transmit controller
`timescale 1ns/1ps
`default_nettype none

module uart_tx_ctrl (
	input  logic                    Clk,
	input  logic                    Rst_n,
	input  logic                    wr,
	input  adc_uart_pkg::addr_t     addr,
	input  adc_uart_pkg::wrdata_t   wrdata,
	input  logic                    adc_flag,
	input  adc_uart_pkg::adc_data_t adc_result,
	uart_tx_if.ctrl                 tx
);
	import adc_uart_pkg::*;

	// host registers.
	logic      tx_en;
	baud_sel_t baud_reg;
	// set by byte_en, cleared by tx_done.
	logic      busy;
	logic      send;

	// results arriving while busy are dropped.
	assign send = adc_flag && tx_en && !busy && !tx.byte_en;

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			tx_en    <= 1'b0;
			baud_reg <= 3'd0;
		end else if (wr && (addr == ADDR_TX_EN)) begin
			tx_en <= wrdata[0];
		end else if (wr && (addr == ADDR_BAUD)) begin
			baud_reg <= wrdata[2:0];
		end
	end

	// baud is frozen per frame here.
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			tx.byte_en  <= 1'b0;
			tx.baud_set <= 3'd0;
		end else begin
			tx.byte_en <= send;
			if (send)
				tx.baud_set <= baud_reg;
		end
	end

	always_ff @(posedge Clk) begin
		if (send)
			tx.data_byte <= adc_result;
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n)
			busy <= 1'b0;
		else if (tx.byte_en)
			busy <= 1'b1;
		else if (tx.tx_done)
			busy <= 1'b0;
	end

	a_byte_en_pulse: assert property (@(posedge Clk) disable iff (!Rst_n)
		tx.byte_en |=> !tx.byte_en);

	// no request between a send and the transmitter's done pulse.
	a_no_send_busy: assert property (@(posedge Clk) disable iff (!Rst_n)
		busy |-> !tx.byte_en);

endmodule

`default_nettype wire

// ==== uart_byte_tx.sv ====
// UART byte transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_byte_tx #(
	parameter int unsigned CLK_FREQ_HZ = 10_000_000
) (
	input  logic   Clk,
	input  logic   Rst_n,
	uart_tx_if.phy tx,
	output logic   txd
);
	import adc_uart_pkg::*;

	// frame sequencing.
	logic        active;
	logic [3:0]  bit_cnt;
	logic [15:0] div_cnt;
	logic        bit_end;
	logic        start;
	// latched per frame.
	logic [15:0] divisor;
	logic [9:0]  frame;

	// new frames only from idle.
	assign start = tx.byte_en && !active;

	// last cycle of the current bit.
	assign bit_end = (div_cnt == divisor - 16'd1);

	// done in the final cycle of the stop bit.
	assign tx.tx_done = active && bit_end && (bit_cnt == 4'd9);

	// bit and divide counters.
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			active  <= 1'b0;
			bit_cnt <= 4'd0;
			div_cnt <= 16'd0;
		end else if (start) begin
			active  <= 1'b1;
			bit_cnt <= 4'd0;
			div_cnt <= 16'd0;
		end else if (active) begin
			if (bit_end) begin
				div_cnt <= 16'd0;
				if (bit_cnt == 4'd9)
					active <= 1'b0;
				else
					bit_cnt <= bit_cnt + 4'd1;
			end else begin
				div_cnt <= div_cnt + 16'd1;
			end
		end
	end

	// stop, data lsb first, start.
	always_ff @(posedge Clk) begin
		if (start) begin
			frame   <= {1'b1, tx.data_byte, 1'b0};
			divisor <= baud_divisor(CLK_FREQ_HZ, tx.baud_set);
		end else if (active && bit_end) begin
			frame <= {1'b1, frame[9:1]};
		end
	end

	// serial line, idles high.
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			txd <= 1'b1;
		end else if (start) begin
			// start bit.
			txd <= 1'b0;
		end else if (active && bit_end) begin
			// next bit sits one above the current one.
			if (bit_cnt == 4'd9)
				txd <= 1'b1;
			else
				txd <= frame[1];
		end
	end

	// line stays marking between frames.
	a_idle_high: assert property (@(posedge Clk) disable iff (!Rst_n)
		!active |-> txd);

endmodule

`default_nettype wire

// ==== adc_uart_top.sv ====
// ADC to UART top level
`timescale 1ns/1ps
`default_nettype none

module adc_uart_top #(
	parameter int unsigned CLK_FREQ_HZ = 10_000_000
) (
	input  logic                    Clk,
	input  logic                    Rst_n,
	// host write bus.
	input  logic                    wr,
	input  adc_uart_pkg::addr_t     addr,
	input  adc_uart_pkg::wrdata_t   wrdata,
	// parallel ADC pins.
	output logic                    adc_conv,
	input  logic                    adc_busy,
	input  adc_uart_pkg::adc_data_t adc_data,
	// serial output.
	output logic                    txd
);
	import adc_uart_pkg::*;

	// sampler to controller.
	logic      adc_flag;
	adc_data_t adc_result;

	// controller to transmitter link.
	uart_tx_if tx_bus ();

	adc_sampler u_sampler (
		.Clk        (Clk),
		.Rst_n      (Rst_n),
		.wr         (wr),
		.addr       (addr),
		.wrdata     (wrdata),
		.adc_conv   (adc_conv),
		.adc_busy   (adc_busy),
		.adc_data   (adc_data),
		.adc_flag   (adc_flag),
		.adc_result (adc_result)
	);

	// one cycle from adc_flag to byte_en.
	uart_tx_ctrl u_ctrl (
		.Clk        (Clk),
		.Rst_n      (Rst_n),
		.wr         (wr),
		.addr       (addr),
		.wrdata     (wrdata),
		.adc_flag   (adc_flag),
		.adc_result (adc_result),
		.tx         (tx_bus.ctrl)
	);

	// start bit one cycle after byte_en.
	uart_byte_tx #(
		.CLK_FREQ_HZ (CLK_FREQ_HZ)
	) u_byte_tx (
		.Clk   (Clk),
		.Rst_n (Rst_n),
		.tx    (tx_bus.phy),
		.txd   (txd)
	);

endmodule

`default_nettype wire

// ==== tb_adc_uart.sv ====
// ADC to UART testbench
`timescale 1ns/1ps
`default_nettype none

module tb_adc_uart;
	import adc_uart_pkg::*;

	localparam int unsigned CLK_FREQ_HZ = 10_000_000;
	localparam int          N_ROWS      = 9;

	// baud, tx_en, period, sample, frames, then conversions, short, mid write, new baud.
	typedef struct packed {
		baud_sel_t   baud;
		logic        tx_en;
		logic [15:0] period;
		adc_data_t   sample;
		logic [7:0]  n_frames;
		logic [7:0]  n_conv;
		logic        shrt;
		logic        mid;
		baud_sel_t   baud2;
	} row_t;

	logic      Clk, Rst_n, wr, adc_conv, adc_busy, txd;
	addr_t     addr;
	wrdata_t   wrdata;
	adc_data_t adc_data;

	row_t        tbl [N_ROWS];
	adc_data_t   presented [$];
	adc_data_t   cur_sample;
	baud_sel_t   cur_baud;
	logic        cur_short, in_frame;
	int          conv_cnt, done_cnt, frames, errors, checks;
	integer      seed;
	longint      limit_ns;

	adc_uart_top #(.CLK_FREQ_HZ(CLK_FREQ_HZ)) UUT (
		.Clk(Clk), .Rst_n(Rst_n), .wr(wr), .addr(addr), .wrdata(wrdata),
		.adc_conv(adc_conv), .adc_busy(adc_busy), .adc_data(adc_data), .txd(txd)
	);

	initial begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;
	end

	task automatic check_byte(input string name, input adc_data_t got, input adc_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("error: %s got %h expected %h", name, got, exp);
		end
	endtask

	// one host write with the strobe held for a single cycle.
	task automatic write_reg(input addr_t a, input wrdata_t d);
		@(posedge Clk);
		wr     <= 1'b1;
		addr   <= a;
		wrdata <= d;
		@(posedge Clk);
		wr <= 1'b0;
	endtask

	// ADC model holds busy for 3 to 20 cycles per conversion.
	initial begin
		int unsigned lat;
		forever begin
			@(negedge Clk);
			if (Rst_n && adc_conv === 1'b1) begin
				lat = 3 + ($unsigned($random(seed)) % 18);
				@(posedge Clk);
				adc_busy <= 1'b1;
				adc_data <= cur_sample + 8'(conv_cnt);
				presented.push_back(cur_sample + 8'(conv_cnt));
				conv_cnt++;
				repeat (lat) @(posedge Clk);
				adc_busy <= 1'b0;
				done_cnt++;
			end
		end
	end

	// frame decoder samples mid bit on the falling clock edge.
	initial begin
		int unsigned div;
		logic        start_bit, stop_bit;
		adc_data_t   rx;
		int          hit;
		in_frame = 1'b0;
		forever begin
			@(negedge Clk);
			if (Rst_n && txd === 1'b0) begin
				in_frame = 1'b1;
				div = baud_divisor(CLK_FREQ_HZ, cur_baud);
				repeat (div / 2) @(negedge Clk);
				start_bit = txd;
				for (int i = 0; i < 8; i++) begin
					repeat (div) @(negedge Clk);
					rx[i] = txd;
				end
				repeat (div) @(negedge Clk);
				stop_bit = txd;
				checks++;
				if (start_bit !== 1'b0 || stop_bit !== 1'b1) begin
					errors++;
					$display("framing error in frame %0d, start or stop bit is wrong", frames);
				end
				// short rows accept any presented sample.
				if (cur_short) begin
					hit = 0;
					foreach (presented[i])
						if (presented[i] == rx)
							hit = 1;
					checks++;
					if (hit == 0) begin
						errors++;
						$display("error: data_byte %h matches no presented sample", rx);
					end
				end else if (frames < presented.size()) begin
					check_byte("data_byte", rx, presented[frames]);
				end else begin
					errors++;
					$display("frame %0d arrived without a conversion before it", frames);
				end
				frames++;
				in_frame = 1'b0;
			end
		end
	end

	// watchdog armed once the limit is known.
	initial begin
		wait (limit_ns != 0);
		#(limit_ns);
		$display("timeout, the run took longer than the tests allow");
		$display("Finished with errors");
		$finish;
	end

	initial begin
		row_t        r;
		int unsigned div;
		int          err0;
		logic        mid_done;
		longint      cyc;
		Rst_n = 1'b0;
		wr = 1'b0;
		addr = '0;
		wrdata = '0;
		adc_busy = 1'b0;
		adc_data = '0;
		seed = 32'h9bbc_7c27;
		cur_sample = '0;
		cur_baud = '0;
		cur_short = 1'b0;
		conv_cnt = 0;
		done_cnt = 0;
		frames = 0;
		errors = 0;
		checks = 0;
		limit_ns = 0;
		tbl[0] = {3'd0, 1'b0, 16'd500,   8'h3c, 8'd0, 8'd3, 1'b0, 1'b0, 3'd0};
		tbl[1] = {3'd0, 1'b1, 16'd11000, 8'ha5, 8'd2, 8'd2, 1'b0, 1'b0, 3'd0};
		tbl[2] = {3'd1, 1'b1, 16'd5600,  8'h5a, 8'd2, 8'd2, 1'b0, 1'b0, 3'd0};
		tbl[3] = {3'd2, 1'b1, 16'd3000,  8'hc3, 8'd3, 8'd3, 1'b0, 1'b0, 3'd0};
		tbl[4] = {3'd3, 1'b1, 16'd2000,  8'h81, 8'd3, 8'd3, 1'b0, 1'b0, 3'd0};
		tbl[5] = {3'd4, 1'b1, 16'd1000,  8'h7e, 8'd3, 8'd3, 1'b0, 1'b0, 3'd0};
		tbl[6] = {3'd6, 1'b1, 16'd11000, 8'h01, 8'd2, 8'd2, 1'b0, 1'b0, 3'd0};
		// baud rewrite during the first frame.
		tbl[7] = {3'd4, 1'b1, 16'd11000, 8'hf0, 8'd2, 8'd2, 1'b0, 1'b1, 3'd0};
		// period shorter than a frame so the frame count is only bounded.
		tbl[8] = {3'd4, 1'b1, 16'd300,   8'h96, 8'd0, 8'd8, 1'b1, 1'b0, 3'd0};
		// window plus 12 frames at the slower rate per row with 20% margin.
		cyc = 100;
		foreach (tbl[i]) begin
			div = baud_divisor(CLK_FREQ_HZ, tbl[i].baud);
			if (tbl[i].mid && baud_divisor(CLK_FREQ_HZ, tbl[i].baud2) > div)
				div = baud_divisor(CLK_FREQ_HZ, tbl[i].baud2);
			cyc += longint'(tbl[i].period) * tbl[i].n_conv + 120 * longint'(div);
		end
		limit_ns = cyc * 12 / 10 * 100;
		repeat (10) @(posedge Clk);
		Rst_n <= 1'b1;
		// idle line and no conversions before sampling is enabled.
		repeat (50) begin
			@(negedge Clk);
			checks++;
			if (txd !== 1'b1) begin
				errors++;
				$display("error: txd got %h expected %h", txd, 1'b1);
			end
		end
		check_count("adc_conv pulses", conv_cnt, 0);
		for (int t = 0; t < N_ROWS; t++) begin
			r = tbl[t];
			err0 = errors;
			mid_done = 1'b0;
			conv_cnt = 0;
			done_cnt = 0;
			frames = 0;
			presented.delete();
			cur_sample = r.sample;
			cur_baud = r.baud;
			cur_short = r.shrt;
			write_reg(ADDR_BAUD, 16'(r.baud));
			write_reg(ADDR_TX_EN, 16'(r.tx_en));
			write_reg(ADDR_SMP_PERIOD, r.period);
			write_reg(ADDR_SMP_EN, 16'd1);
			while (conv_cnt < r.n_conv) begin
				@(posedge Clk);
				// decoder has latched the old rate by now.
				if (r.mid && !mid_done && in_frame) begin
					write_reg(ADDR_BAUD, 16'(r.baud2));
					cur_baud = r.baud2;
					mid_done = 1'b1;
				end
			end
			write_reg(ADDR_SMP_EN, 16'd0);
			// last result, then its frame, then the rest of the stop bit.
			while (done_cnt < r.n_conv)
				@(posedge Clk);
			repeat (8) @(posedge Clk);
			while (in_frame)
				@(posedge Clk);
			repeat (baud_divisor(CLK_FREQ_HZ, cur_baud) + 2) @(posedge Clk);
			if (r.shrt) begin
				checks++;
				if (frames == 0 || frames >= conv_cnt) begin
					errors++;
					$display("short period gave %0d frames for %0d conversions", frames, conv_cnt);
				end
			end else begin
				check_count("frames", frames, r.n_frames);
			end
			$display("test %0d baud %0d tx_en %0d: %0d conversions, %0d frames, %0d new errors",
				t, r.baud, r.tx_en, conv_cnt, frames, errors - err0);
		end
		$display("%0d tests, %0d checks, %0d errors", N_ROWS, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
adc_uart_pkg.sv
uart_tx_if.sv
adc_sampler.sv
uart_tx_ctrl.sv
uart_byte_tx.sv
adc_uart_top.sv
tb_adc_uart.sv

// ==== Bender.yml ====
package:
  name: adc_uart

sources:
  - adc_uart_pkg.sv
  - uart_tx_if.sv
  - adc_sampler.sv
  - uart_tx_ctrl.sv
  - uart_byte_tx.sv
  - adc_uart_top.sv
  - target: test
    files:
      - tb_adc_uart.sv
